// ==== files.f ====
rtl/video_pkg.sv
rtl/gb_memmap.sv
rtl/lr35902_vram.sv
rtl/lr35902_oam.sv
rtl/lr35902_ppu_regs.sv
rtl/lr35902_dma.sv
rtl/video_top.sv
testbench/video_tb.sv

// ==== rtl/gb_memmap.sv ====
`timescale 1ns/1ps

module gb_memmap (
	input  video_pkg::bus_adr_t adr,
	input  logic                en,
	output logic                sel_vram,
	output logic                sel_oam,
	output logic                sel_ppu,
	output logic                sel_dma_reg,
	output logic                sel_ext,
	output video_pkg::ppu_reg_e reg_sel
);
	import video_pkg::*;

	logic ppu_hit;

	// only the four implemented registers in 0xFF4x are claimed by the PPU
	always_comb begin
		ppu_hit = 1'b0;
		reg_sel = reg_lcdc;
		if (adr[15:4] == ppu_base[15:4]) begin
			case (adr[3:0])
			reg_lcdc, reg_stat, reg_ly, reg_lyc: begin
				ppu_hit = 1'b1;
				reg_sel = ppu_reg_e'(adr[3:0]);
			end
			default: ;
			endcase
		end
	end

	assign sel_vram    = en && (adr >= vram_first) && (adr <= vram_last);
	assign sel_oam     = en && (adr >= oam_first) && (adr <= oam_last);
	assign sel_ppu     = en && ppu_hit;
	assign sel_dma_reg = en && (adr == dma_reg_adr);
	assign sel_ext     = en && !(sel_vram || sel_oam || sel_ppu || sel_dma_reg);

	always_comb begin
		assert #0 ($onehot0({sel_vram, sel_oam, sel_ppu, sel_dma_reg, sel_ext}))
			else $error("gb_memmap: more than one select for address %h", adr);
	end

endmodule

// ==== rtl/lr35902_dma.sv ====
`timescale 1ns/1ps

module lr35902_dma (
	input  logic                 gbclk,
	input  logic                 rst_n,
	input  logic                 start,
	input  video_pkg::bus_data_t page,
	input  logic                 src_vram,
	input  video_pkg::bus_data_t src_data,
	output video_pkg::bus_adr_t  src_adr,
	output logic                 src_rd,
	output video_pkg::oam_adr_t  oam_adr,
	output video_pkg::bus_data_t oam_din,
	output logic                 oam_wr,
	output logic                 busy,
	output logic                 drive_ext
);
	import video_pkg::*;

	dma_state_e state;
	bus_data_t  page_q;
	oam_adr_t   idx;
	oam_adr_t   idx_q;    // index of the byte in flight
	logic       valid_q;

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			state   <= dma_idle;
			idx     <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= (state == dma_copy);
			case (state)
			dma_idle: begin
				if (start) begin
					state <= dma_copy;
					idx   <= '0;
				end
			end
			dma_copy: begin
				idx <= idx + 1'b1;
				if (idx == oam_adr_t'(oam_len - 1)) begin
					state <= dma_drain;  // last byte still returning
				end
			end
			dma_drain: state <= dma_idle;
			default:   state <= dma_idle;
			endcase
		end
	end

	always_ff @(posedge gbclk) begin
		if ((state == dma_idle) && start) begin
			page_q <= page;
		end
		idx_q <= idx;
	end

	assign src_adr   = {page_q, idx};
	assign src_rd    = (state == dma_copy);
	assign oam_adr   = idx_q;
	assign oam_din   = src_data;
	assign oam_wr    = valid_q;
	assign busy      = (state != dma_idle);
	assign drive_ext = src_rd && !src_vram;

	assert property (@(posedge gbclk) disable iff (!rst_n) oam_wr |-> state != dma_idle)
		else $error("lr35902_dma: OAM write while idle");

endmodule

// ==== rtl/lr35902_oam.sv ====
`timescale 1ns/1ps

module lr35902_oam (
	input  logic                 gbclk,
	input  video_pkg::oam_adr_t  adr,
	input  video_pkg::bus_data_t din,
	input  logic                 rd,
	input  logic                 wr,
	output video_pkg::bus_data_t dout
);
	import video_pkg::*;

	bus_data_t mem [0:oam_len-1];
	logic      in_range;

	assign in_range = (adr < oam_adr_t'(oam_len));

	always_ff @(posedge gbclk) begin
		if (wr && in_range) begin
			mem[adr] <= din;
		end
	end

	always_ff @(posedge gbclk) begin
		if (rd) begin
			dout <= in_range ? mem[adr] : 8'hFF;  // the unused tail reads as open bus
		end
	end

	assert property (@(posedge gbclk) wr |-> in_range)
		else $error("lr35902_oam: write to index %0d", adr);

endmodule

// ==== rtl/lr35902_ppu_regs.sv ====
`timescale 1ns/1ps

module lr35902_ppu_regs #(
	parameter int unsigned line_cycles = 456
) (
	input  logic                 gbclk,
	input  logic                 rst_n,
	input  video_pkg::ppu_reg_e  reg_sel,
	input  logic                 rd,
	input  logic                 wr,
	input  video_pkg::bus_data_t din,
	output video_pkg::bus_data_t dout,
	output logic                 irq_vblank,
	output logic                 irq_stat
);
	import video_pkg::*;

	localparam int cnt_w = $clog2(line_cycles);

	bus_data_t        lcdc;
	logic [3:0]       stat_ie;  // writable STAT bits 6 to 3
	ly_t              ly;
	ly_t              lyc;
	ly_t              ly_next;
	logic [cnt_w-1:0] cyc;
	logic             line_end;
	logic             lyc_flag;

	////////////////////////////////////////////////////////////////////////////
	// line timing

	assign line_end = lcdc[7] && (cyc == cnt_w'(line_cycles - 1));
	assign ly_next  = (ly == ly_t'(lines_per_frame - 1)) ? ly_t'(0) : ly + 1'b1;
	assign lyc_flag = (ly == lyc);

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			cyc        <= '0;
			ly         <= '0;
			irq_vblank <= 1'b0;
			irq_stat   <= 1'b0;
		end else begin
			irq_vblank <= line_end && (ly_next == ly_t'(vblank_line));
			irq_stat   <= line_end && stat_ie[3] && (ly_next == lyc);  // LYC coincidence enable
			if (!lcdc[7]) begin
				cyc <= '0;
				ly  <= '0;
			end else if (line_end) begin
				cyc <= '0;
				ly  <= ly_next;
			end else begin
				cyc <= cyc + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// register file

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			lcdc    <= '0;
			stat_ie <= '0;
			lyc     <= '0;
		end else if (wr) begin
			case (reg_sel)
			reg_lcdc: lcdc    <= din;
			reg_stat: stat_ie <= din[6:3];
			reg_lyc:  lyc     <= din;
			default: ;  // LY is read only
			endcase
		end
	end

	always_ff @(posedge gbclk) begin
		if (rd) begin
			case (reg_sel)
			reg_lcdc: dout <= lcdc;
			reg_stat: dout <= {1'b1, stat_ie, lyc_flag, 2'b00};  // mode bits stay 0
			reg_ly:   dout <= ly;
			reg_lyc:  dout <= lyc;
			default:  dout <= 8'hFF;
			endcase
		end
	end

	assert property (@(posedge gbclk) disable iff (!rst_n) ly < ly_t'(lines_per_frame))
		else $error("lr35902_ppu_regs: LY out of range");

	assert property (@(posedge gbclk) disable iff (!rst_n) irq_vblank |=> !irq_vblank)
		else $error("lr35902_ppu_regs: vblank pulse longer than one cycle");

endmodule

// ==== rtl/lr35902_vram.sv ====
`timescale 1ns/1ps

module lr35902_vram (
	input  logic                  gbclk,
	input  video_pkg::vram_adr_t  adr,
	input  video_pkg::bus_data_t  din,
	input  logic                  rd,
	input  logic                  wr,
	output video_pkg::bus_data_t  dout
);
	import video_pkg::*;

	localparam int vram_size = 8192;

	bus_data_t mem [0:vram_size-1];

	always_ff @(posedge gbclk) begin
		if (wr) begin
			mem[adr] <= din;
		end
	end

	// dout holds its value between reads
	always_ff @(posedge gbclk) begin
		if (rd) begin
			dout <= mem[adr];
		end
	end

endmodule

// ==== rtl/video_pkg.sv ====
package video_pkg;

	typedef logic [15:0] bus_adr_t;
	typedef logic [7:0]  bus_data_t;
	typedef logic [12:0] vram_adr_t;
	typedef logic [7:0]  oam_adr_t;
	typedef logic [7:0]  ly_t;

	// low nibble of the 0xFF4x register address
	typedef enum logic [3:0] {
		reg_lcdc = 4'h0,
		reg_stat = 4'h1,
		reg_ly   = 4'h4,
		reg_lyc  = 4'h5
	} ppu_reg_e;

	typedef enum logic [1:0] {
		dma_idle,
		dma_copy,
		dma_drain
	} dma_state_e;

	localparam bus_adr_t vram_first  = 16'h8000;
	localparam bus_adr_t vram_last   = 16'h9FFF;
	localparam bus_adr_t oam_first   = 16'hFE00;
	localparam bus_adr_t oam_last    = 16'hFE9F;
	localparam bus_adr_t ppu_base    = 16'hFF40;
	localparam bus_adr_t dma_reg_adr = 16'hFF46;

	localparam int oam_len         = 160;  // bytes per OAM DMA transfer
	localparam int lines_per_frame = 154;
	localparam int vblank_line     = 144;

endpackage

// ==== rtl/video_top.sv ====
`timescale 1ns/1ps

module video_top #(
	parameter int unsigned line_cycles = 456
) (
	input  logic                 gbclk,
	input  logic                 rst_n,
	input  video_pkg::bus_adr_t  adr_in,
	input  video_pkg::bus_data_t data_in,
	input  logic                 n_read_in,
	input  logic                 n_write_in,
	input  logic                 n_cs_vid,
	output video_pkg::bus_data_t data_out,
	output logic                 data_oe,
	output video_pkg::bus_adr_t  adr_out,
	output logic                 adr_oe,
	output logic                 n_read_out,
	output logic                 n_dmadrv,
	output logic                 n_irq_vb,
	output logic                 n_irq_st
);
	import video_pkg::*;

	logic      cpu_en;
	logic      cpu_rd;
	logic      cpu_wr;
	logic      cs_vram;
	logic      cs_oam;
	logic      cs_ppu;
	logic      cs_dma_reg;
	ppu_reg_e  reg_sel;
	logic      vram_dma;     // DMA owns VRAM
	bus_adr_t  dma_src_adr;
	logic      dma_src_rd;
	oam_adr_t  dma_oam_adr;
	bus_data_t dma_oam_din;
	logic      dma_oam_wr;
	logic      dma_busy;
	logic      dma_drive_ext;
	vram_adr_t vram_adr;
	logic      vram_rd;
	logic      vram_wr;
	bus_data_t vram_dout;
	oam_adr_t  oam_adr;
	bus_data_t oam_din;
	logic      oam_rd;
	logic      oam_wr;
	bus_data_t oam_dout;
	bus_data_t ppu_dout;
	logic      irq_vblank;
	logic      irq_stat;
	logic      rd_vram_q;
	logic      rd_oam_q;
	logic      rd_ppu_q;

	// the CPU is locked out while the DMA owns the address bus
	assign cpu_en = !n_cs_vid && !adr_oe;
	assign cpu_rd = cpu_en && !n_read_in;
	assign cpu_wr = cpu_en && !n_write_in;

	gb_memmap ext_map (
		.adr(adr_in),
		.en(cpu_en),
		.sel_vram(cs_vram),
		.sel_oam(cs_oam),
		.sel_ppu(cs_ppu),
		.sel_dma_reg(cs_dma_reg),
		.sel_ext(),
		.reg_sel(reg_sel)
	);

	gb_memmap dma_map (
		.adr(dma_src_adr),
		.en(dma_busy),
		.sel_vram(vram_dma),
		.sel_oam(),
		.sel_ppu(),
		.sel_dma_reg(),
		.sel_ext(),
		.reg_sel()
	);

	////////////////////////////////////////////////////////////////////////////
	// memory ownership

	assign vram_adr = vram_dma ? dma_src_adr[12:0] : adr_in[12:0];
	assign vram_rd  = vram_dma ? dma_src_rd : (cpu_rd && cs_vram);
	assign vram_wr  = !vram_dma && cpu_wr && cs_vram;

	assign oam_adr = dma_busy ? dma_oam_adr : adr_in[7:0];
	assign oam_din = dma_busy ? dma_oam_din : data_in;
	assign oam_rd  = !dma_busy && cpu_rd && cs_oam;
	assign oam_wr  = dma_busy ? dma_oam_wr : (cpu_wr && cs_oam);

	lr35902_vram vram (
		.gbclk(gbclk),
		.adr(vram_adr),
		.din(data_in),
		.rd(vram_rd),
		.wr(vram_wr),
		.dout(vram_dout)
	);

	lr35902_oam oam (
		.gbclk(gbclk),
		.adr(oam_adr),
		.din(oam_din),
		.rd(oam_rd),
		.wr(oam_wr),
		.dout(oam_dout)
	);

	lr35902_ppu_regs #(
		.line_cycles(line_cycles)
	) ppu (
		.gbclk(gbclk),
		.rst_n(rst_n),
		.reg_sel(reg_sel),
		.rd(cpu_rd && cs_ppu),
		.wr(cpu_wr && cs_ppu),
		.din(data_in),
		.dout(ppu_dout),
		.irq_vblank(irq_vblank),
		.irq_stat(irq_stat)
	);

	lr35902_dma dma (
		.gbclk(gbclk),
		.rst_n(rst_n),
		.start(cpu_wr && cs_dma_reg),
		.page(data_in),
		.src_vram(vram_dma),
		.src_data(vram_dma ? vram_dout : data_in),  // VRAM or external source byte
		.src_adr(dma_src_adr),
		.src_rd(dma_src_rd),
		.oam_adr(dma_oam_adr),
		.oam_din(dma_oam_din),
		.oam_wr(dma_oam_wr),
		.busy(dma_busy),
		.drive_ext(dma_drive_ext)
	);

	////////////////////////////////////////////////////////////////////////////
	// read data and pins

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			data_oe   <= 1'b0;
			rd_vram_q <= 1'b0;
			rd_oam_q  <= 1'b0;
			rd_ppu_q  <= 1'b0;
		end else begin
			data_oe   <= cpu_rd;
			rd_vram_q <= cpu_rd && cs_vram && !vram_dma;
			rd_oam_q  <= oam_rd;
			rd_ppu_q  <= cpu_rd && cs_ppu;
		end
	end

	always_comb begin
		if (rd_ppu_q) begin
			data_out = ppu_dout;
		end else if (rd_vram_q) begin
			data_out = vram_dout;
		end else if (rd_oam_q) begin
			data_out = oam_dout;
		end else begin
			data_out = 8'hFF;  // unmapped, blocked or DMA register
		end
	end

	assign adr_out    = dma_src_adr;
	assign adr_oe     = dma_drive_ext;
	assign n_read_out = !(dma_src_rd && dma_drive_ext);
	assign n_dmadrv   = !dma_drive_ext;
	assign n_irq_vb   = !irq_vblank;
	assign n_irq_st   = !irq_stat;

endmodule

// ==== testbench/video_tb.sv ====
`timescale 1ns/1ps

module video_tb;
	import video_pkg::*;

	localparam int line_cycles  = 8;
	localparam int clk_period   = 8;
	localparam int frame_cycles = lines_per_frame * line_cycles;
	localparam int test_cycles  = frame_cycles + 2 * (oam_len + 1);  // one frame and two DMAs

	logic      gbclk;
	logic      rst_n;
	bus_adr_t  adr_in;
	bus_data_t data_in;
	bus_data_t cpu_data;
	logic      n_read_in;
	logic      n_write_in;
	logic      n_cs_vid;
	bus_data_t data_out;
	logic      data_oe;
	bus_adr_t  adr_out;
	logic      adr_oe;
	logic      n_read_out;
	logic      n_dmadrv;
	logic      n_irq_vb;
	logic      n_irq_st;

	bus_data_t   vram_exp [0:8191];
	bus_data_t   oam_exp [0:oam_len-1];
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          cycle = 0;
	int          ext_cnt = 0;
	bus_adr_t    dma_base = 16'h0000;
	logic [31:0] lcg_state = 32'd52;
	logic        ext_req = 1'b0;
	logic        ext_drive = 1'b0;
	bus_adr_t    ext_req_adr = 16'h0000;
	bus_data_t   ext_byte = 8'h00;
	logic        cpu_rd_strobe;

	video_top #(
		.line_cycles(line_cycles)
	) uut (
		.gbclk(gbclk),
		.rst_n(rst_n),
		.adr_in(adr_in),
		.data_in(data_in),
		.n_read_in(n_read_in),
		.n_write_in(n_write_in),
		.n_cs_vid(n_cs_vid),
		.data_out(data_out),
		.data_oe(data_oe),
		.adr_out(adr_out),
		.adr_oe(adr_oe),
		.n_read_out(n_read_out),
		.n_dmadrv(n_dmadrv),
		.n_irq_vb(n_irq_vb),
		.n_irq_st(n_irq_st)
	);

	assign data_in       = ext_drive ? ext_byte : cpu_data;  // external memory answers DMA reads
	assign cpu_rd_strobe = !n_cs_vid && !adr_oe && !n_read_in;

	initial begin
		gbclk = 1'b0;
		forever #(clk_period / 2) gbclk = ~gbclk;
	end

	initial begin
		#(20 * test_cycles * clk_period);
		$display("watchdog: the run did not finish within %0d cycles", 20 * test_cycles);
		$display("Finished with errors");
		$finish;
	end

	always @(posedge gbclk) begin
		cycle <= cycle + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// external memory with one cycle of read latency

	function automatic bus_data_t ext_byte_at(input bus_adr_t a);
		return a[7:0] ^ 8'h5A;
	endfunction

	always @(negedge gbclk) begin
		ext_req     = (n_read_out === 1'b0);
		ext_req_adr = adr_out;
	end

	always @(posedge gbclk) begin
		#1;
		ext_drive = ext_req;
		ext_byte  = ext_byte_at(ext_req_adr);
	end

	// external DMA cycles walk the source page in order
	always @(negedge gbclk) begin
		if (adr_oe === 1'b1) begin
			assert ((adr_out == dma_base + bus_adr_t'(ext_cnt)) && !n_dmadrv && !n_read_out)
				else begin
					errors++;
					$display("[FAIL] %0t ns: DMA cycle %0d drove address %h", $time, ext_cnt,
						adr_out);
				end
			ext_cnt++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// protocol checks

	assert property (@(posedge gbclk) disable iff (!rst_n) cpu_rd_strobe |=> data_oe)
		else begin
			errors++;
			$display("[FAIL] %0t ns: data_oe missing after a read", $time);
		end
	assert property (@(posedge gbclk) disable iff (!rst_n) !cpu_rd_strobe |=> !data_oe)
		else begin
			errors++;
			$display("[FAIL] %0t ns: data_oe without a read", $time);
		end
	assert property (@(posedge gbclk) disable iff (!rst_n) !n_irq_vb |=> n_irq_vb)
		else begin
			errors++;
			$display("[FAIL] %0t ns: n_irq_vb low too long", $time);
		end
	assert property (@(posedge gbclk) disable iff (!rst_n) !n_irq_st |=> n_irq_st)
		else begin
			errors++;
			$display("[FAIL] %0t ns: n_irq_st low too long", $time);
		end
	assert property (@(posedge gbclk) disable iff (!rst_n) n_dmadrv == !adr_oe)
		else begin
			errors++;
			$display("[FAIL] %0t ns: n_dmadrv and adr_oe differ", $time);
		end

	function automatic bus_data_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	function automatic logic probe(input int which);
		case (which)
		0: return adr_oe;
		1: return n_irq_vb;
		default: return n_irq_st;
		endcase
	endfunction

	task automatic check(input string what, input int got, input int exp);
		checks++;
		assert (got == exp)
			else begin
				errors++;
				$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			end
	endtask

	task automatic bus_write(input bus_adr_t a, input bus_data_t d);
		adr_in     = a;
		cpu_data   = d;
		n_cs_vid   = 1'b0;
		n_write_in = 1'b0;
		@(posedge gbclk);
		#1;
		n_write_in = 1'b1;
		n_cs_vid   = 1'b1;
	endtask

	// the byte comes back in the cycle after the strobe
	task automatic bus_read(input bus_adr_t a, input logic cs, output bus_data_t d,
			output logic oe);
		adr_in    = a;
		n_cs_vid  = !cs;
		n_read_in = 1'b0;
		@(posedge gbclk);
		#1;
		n_read_in = 1'b1;
		n_cs_vid  = 1'b1;
		d         = data_out;
		oe        = data_oe;
	endtask

	task automatic wait_level(input int which, input logic level, input int limit,
			input string what);
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			@(posedge gbclk);
			#1;
			seen = (probe(which) === level);
		end
		if (!seen) begin
			errors++;
			$display("timeout: %s did not happen within %0d cycles", what, limit);
		end
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		$display("test %0d (%s): %0d errors", tests, name, errors - err0);
	endtask

	initial begin
		bus_data_t d;
		bus_data_t hi;
		bus_data_t lo;
		logic      oe;
		bus_adr_t  adrs [0:31];
		int        err0;
		int        t_vb1;
		int        t_vb2;

		rst_n      = 1'b0;
		adr_in     = '0;
		cpu_data   = '0;
		n_read_in  = 1'b1;
		n_write_in = 1'b1;
		n_cs_vid   = 1'b1;
		repeat (2) @(posedge gbclk);
		#1;
		rst_n = 1'b1;

		err0 = errors;
		for (int i = 0; i < 32; i++) begin
			hi      = lcg_next();
			lo      = lcg_next();
			d       = lcg_next();
			adrs[i] = {3'b100, hi[4:0], lo};
			vram_exp[adrs[i][12:0]] = d;
			bus_write(adrs[i], d);
		end
		for (int i = 0; i < 32; i++) begin
			bus_read(adrs[i], 1'b1, d, oe);
			check("VRAM byte", d, vram_exp[adrs[i][12:0]]);
			check("data_oe", oe, 1);
		end
		bus_read(adrs[0], 1'b0, d, oe);
		check("data_oe with n_cs_vid high", oe, 0);
		end_test("VRAM read back", err0);

		err0 = errors;
		for (int k = 0; k < oam_len; k++) begin
			oam_exp[k] = lcg_next();
			bus_write(oam_first + bus_adr_t'(k), oam_exp[k]);
		end
		for (int k = 0; k < oam_len; k++) begin
			bus_read(oam_first + bus_adr_t'(k), 1'b1, d, oe);
			check("OAM byte", d, oam_exp[k]);
		end
		bus_read(16'hFEA0, 1'b1, d, oe);
		check("read of 0xFEA0", d, 8'hFF);
		end_test("OAM read back", err0);

		err0 = errors;
		bus_read(16'hFF40, 1'b1, d, oe);
		check("LCDC after reset", d, 0);
		bus_read(16'hFF44, 1'b1, d, oe);
		check("LY after reset", d, 0);
		bus_write(16'hFF40, 8'h13);
		bus_read(16'hFF40, 1'b1, d, oe);
		check("LCDC", d, 8'h13);
		bus_write(16'hFF45, 8'h05);
		bus_read(16'hFF45, 1'b1, d, oe);
		check("LYC", d, 8'h05);
		bus_write(16'hFF44, 8'h77);
		bus_read(16'hFF44, 1'b1, d, oe);
		check("LY after a write", d, 0);
		bus_read(16'hFF41, 1'b1, d, oe);
		check("STAT bit 2 with LY != LYC", d[2], 0);
		bus_write(16'hFF45, 8'h00);
		bus_read(16'hFF41, 1'b1, d, oe);
		check("STAT bit 2 with LY == LYC", d[2], 1);
		end_test("PPU registers", err0);

		err0 = errors;
		bus_write(16'hFF45, 8'd10);
		bus_write(16'hFF41, 8'h40);  // LYC interrupt enable
		bus_write(16'hFF40, 8'h80);
		wait_level(1, 1'b0, 2 * frame_cycles, "first vblank interrupt");
		t_vb1 = cycle;
		bus_read(16'hFF44, 1'b1, d, oe);
		check("LY at vblank", d, vblank_line);
		wait_level(1, 1'b0, 2 * frame_cycles, "second vblank interrupt");
		t_vb2 = cycle;
		check("cycles between vblank interrupts", t_vb2 - t_vb1, frame_cycles);
		wait_level(2, 1'b0, frame_cycles, "STAT interrupt");
		bus_read(16'hFF44, 1'b1, d, oe);
		check("LY at STAT interrupt", d, 10);
		bus_read(16'hFF41, 1'b1, d, oe);
		check("STAT bit 2 at STAT interrupt", d[2], 1);
		bus_write(16'hFF40, 8'h00);
		end_test("line counter and interrupts", err0);

		err0 = errors;
		ext_cnt  = 0;
		dma_base = 16'hC100;
		bus_write(dma_reg_adr, 8'hC1);
		wait_level(0, 1'b1, 8, "start of external DMA");
		wait_level(0, 1'b0, oam_len + 8, "end of external DMA");
		repeat (2) @(posedge gbclk);
		#1;
		check("external DMA cycles", ext_cnt, oam_len);
		for (int k = 0; k < oam_len; k++) begin
			oam_exp[k] = bus_data_t'(k) ^ 8'h5A;
			bus_read(oam_first + bus_adr_t'(k), 1'b1, d, oe);
			check("OAM byte after external DMA", d, oam_exp[k]);
		end
		end_test("DMA from the external bus", err0);

		err0 = errors;
		for (int k = 0; k < oam_len; k++) begin
			d = lcg_next();
			vram_exp[k] = d;
			bus_write(vram_first + bus_adr_t'(k), d);
		end
		ext_cnt = 0;
		bus_write(dma_reg_adr, 8'h80);
		bus_read(oam_first + 16'd5, 1'b1, d, oe);
		check("OAM read during DMA", d, 8'hFF);
		check("data_oe during DMA", oe, 1);
		for (int i = 0; i < oam_len + 4; i++) begin
			@(posedge gbclk);
			#1;
			check("n_dmadrv during VRAM DMA", n_dmadrv, 1);
		end
		check("external cycles of VRAM DMA", ext_cnt, 0);
		for (int k = 0; k < oam_len; k++) begin
			oam_exp[k] = vram_exp[k];
			bus_read(oam_first + bus_adr_t'(k), 1'b1, d, oe);
			check("OAM byte after VRAM DMA", d, oam_exp[k]);
		end
		end_test("DMA from VRAM", err0);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
